// ==== design/pcs_rx_defines.svh ====
//////////////////////////////////////////////////////////////////////
// PCS receive constants
// Lane geometry, 64b/66b sync headers and block type codes,
// XGMII control characters and the descrambler polynomial taps
//////////////////////////////////////////////////////////////////////

`ifndef PCS_RX_DEFINES_SVH
`define PCS_RX_DEFINES_SVH

// Lane geometry
`define PCS_LANES      4
`define PCS_PAYLOAD_W  64
`define PCS_HDR_W      2
`define PCS_CTRL_W     8

// Sync headers
`define HDR_DATA       2'b01
`define HDR_CTRL       2'b10

// Block type field of a control block
`define BT_IDLE        8'h1E
`define BT_START       8'h78
`define BT_TERM0       8'h87

// XGMII characters
`define XG_IDLE        8'h07
`define XG_START       8'hFB
`define XG_TERM        8'hFD
`define XG_ERROR       8'hFE

// Descrambler taps, x^58 + x^39 + 1
`define SCR_TAP_A      38
`define SCR_TAP_B      57

// Errored-block counter
`define ERRCNT_W       8

`endif

// ==== design/pcs_rx_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// PCS receive types
// Block payload view and the per-lane array types carried
// between the descrambler, decoder and frame monitor
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pcs_rx_defines.svh"

package pcs_rx_pkg;

    // Control block layout, type byte is the first byte on the wire
    typedef struct packed {
        logic [`PCS_PAYLOAD_W-9:0] body;
        logic [7:0]                btype;
    } ctrl_view_t;

    // Same 64 bits, read as data or as control depending on the header
    typedef union packed {
        logic [`PCS_PAYLOAD_W/8-1:0][7:0] data_bytes;
        ctrl_view_t                       ctrl;
    } block_payload_u;

    //////////////////////////////////////////////////////////////////////
    // Lane arrays, lane 0 in the low bits
    //////////////////////////////////////////////////////////////////////
    typedef logic [`PCS_LANES-1:0][`PCS_HDR_W-1:0]     lane_hdr_t;
    typedef logic [`PCS_LANES-1:0][`PCS_PAYLOAD_W-1:0] lane_payload_t;
    typedef logic [`PCS_LANES-1:0][`PCS_CTRL_W-1:0]    lane_rxc_t;
    typedef logic [`PCS_LANES-1:0][`PCS_PAYLOAD_W-1:0] lane_rxd_t;

endpackage

`default_nettype wire

// ==== design/rx_descrambler.sv ====
//////////////////////////////////////////////////////////////////////
// Four-lane chained descrambler
// Self-synchronising x^58 + x^39 + 1 descrambler run over all lanes
// in order, history from lane 3 carried into lane 0 of the next word
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pcs_rx_defines.svh"

module rx_descrambler (
    input  wire                        clk_156,
    input  wire                        async_reset_n,
    input  wire                        advance_i,
    input  wire                        valid_i,
    input  pcs_rx_pkg::lane_hdr_t      hdr_i,
    input  pcs_rx_pkg::lane_payload_t  payload_i,
    input  wire                        bypass_i,
    output logic                       valid_o,
    output pcs_rx_pkg::lane_hdr_t      hdr_o,
    output pcs_rx_pkg::lane_payload_t  payload_o
);

    localparam int HIST_W = `SCR_TAP_B + 1;

    logic [HIST_W-1:0]         hist_q;
    logic [HIST_W-1:0]         hist_next;
    pcs_rx_pkg::lane_payload_t descr_c;

    //////////////////////////////////////////////////////////////////////
    // Descramble, lane 0 first, bit 0 first
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        hist_next = hist_q;
        descr_c   = payload_i;
        for (int ln = 0; ln < `PCS_LANES; ln++) begin
            for (int b = 0; b < `PCS_PAYLOAD_W; b++) begin
                descr_c[ln][b] = payload_i[ln][b]
                               ^ hist_next[`SCR_TAP_A]
                               ^ hist_next[`SCR_TAP_B];
                // Received bit enters the history, most recent at bit 0
                hist_next = {hist_next[HIST_W-2:0], payload_i[ln][b]};
            end
        end
    end

    // History keeps running in bypass so a later switch stays in sync
    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            hist_q <= '0;
        end else if (advance_i && valid_i) begin
            hist_q <= hist_next;
        end
    end

    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            valid_o <= 1'b0;
        end else if (advance_i) begin
            valid_o <= valid_i;
        end
    end

    // Stage payload, headers pass through untouched
    always_ff @(posedge clk_156) begin
        if (advance_i) begin
            hdr_o     <= hdr_i;
            payload_o <= bypass_i ? payload_i : descr_c;
        end
    end

endmodule

`default_nettype wire

// ==== design/block_decoder.sv ====
//////////////////////////////////////////////////////////////////////
// 64b/66b block decoder
// Turns each descrambled block into XGMII control and data and flags
// start, terminate and errored blocks per lane
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pcs_rx_defines.svh"

module block_decoder (
    input  wire                        clk_156,
    input  wire                        async_reset_n,
    input  wire                        advance_i,
    input  wire                        valid_i,
    input  pcs_rx_pkg::lane_hdr_t      hdr_i,
    input  pcs_rx_pkg::lane_payload_t  payload_i,
    output logic                       valid_o,
    output pcs_rx_pkg::lane_rxc_t      rxc_o,
    output pcs_rx_pkg::lane_rxd_t      rxd_o,
    output logic [`PCS_LANES-1:0]      start_o,
    output logic [`PCS_LANES-1:0]      term_o,
    output logic [`PCS_LANES-1:0]      err_o
);

    localparam int BYTES = `PCS_PAYLOAD_W / 8;

    pcs_rx_pkg::block_payload_u [`PCS_LANES-1:0] blk_c;
    pcs_rx_pkg::lane_rxc_t                       rxc_c;
    pcs_rx_pkg::lane_rxd_t                       rxd_c;
    logic [`PCS_LANES-1:0]                       start_c;
    logic [`PCS_LANES-1:0]                       term_c;
    logic [`PCS_LANES-1:0]                       err_c;

    assign blk_c = payload_i;

    //////////////////////////////////////////////////////////////////////
    // Per-lane decode
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int ln = 0; ln < `PCS_LANES; ln++) begin
            // Error word unless a known block matches below
            rxc_c[ln]   = {`PCS_CTRL_W{1'b1}};
            rxd_c[ln]   = {BYTES{`XG_ERROR}};
            start_c[ln] = 1'b0;
            term_c[ln]  = 1'b0;
            err_c[ln]   = 1'b0;

            if (hdr_i[ln] == `HDR_DATA) begin
                rxc_c[ln] = '0;
                rxd_c[ln] = blk_c[ln].data_bytes;
            end else if (hdr_i[ln] == `HDR_CTRL) begin
                case (blk_c[ln].ctrl.btype)
                    `BT_IDLE: begin
                        rxd_c[ln] = {BYTES{`XG_IDLE}};
                    end
                    `BT_START: begin
                        // Start in lane byte 0, seven data bytes follow
                        rxc_c[ln]   = `PCS_CTRL_W'(1);
                        rxd_c[ln]   = {blk_c[ln].ctrl.body, `XG_START};
                        start_c[ln] = 1'b1;
                    end
                    `BT_TERM0: begin
                        rxd_c[ln]  = {{(BYTES-1){`XG_IDLE}}, `XG_TERM};
                        term_c[ln] = 1'b1;
                    end
                    default: begin
                        err_c[ln] = 1'b1;
                    end
                endcase
            end else begin
                // Headers 00 and 11 are never legal
                err_c[ln] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            valid_o <= 1'b0;
        end else if (advance_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_156) begin
        if (advance_i) begin
            rxc_o   <= rxc_c;
            rxd_o   <= rxd_c;
            start_o <= start_c;
            term_o  <= term_c;
            err_o   <= err_c;
        end
    end

endmodule

`default_nettype wire

// ==== design/frame_monitor.sv ====
//////////////////////////////////////////////////////////////////////
// Frame monitor and output stage
// Holds the XGMII output word, follows start and terminate across
// lanes and counts errored blocks with saturation
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pcs_rx_defines.svh"

module frame_monitor (
    input  wire                        clk_156,
    input  wire                        async_reset_n,
    input  wire                        advance_i,
    input  wire                        valid_i,
    input  pcs_rx_pkg::lane_rxc_t      rxc_i,
    input  pcs_rx_pkg::lane_rxd_t      rxd_i,
    input  wire  [`PCS_LANES-1:0]      start_i,
    input  wire  [`PCS_LANES-1:0]      term_i,
    input  wire  [`PCS_LANES-1:0]      err_i,
    input  wire                        clear_errblk_i,
    output logic                       valid_o,
    output pcs_rx_pkg::lane_rxc_t      rxc_o,
    output pcs_rx_pkg::lane_rxd_t      rxd_o,
    output logic                       in_frame_o,
    output logic [`ERRCNT_W-1:0]       errd_blks_o
);

    localparam int NERR_W = $clog2(`PCS_LANES + 1);

    logic              in_frame_c;
    logic [NERR_W-1:0] nerr_c;
    logic [`ERRCNT_W:0] errd_sum;

    // Walk lanes 0 to 3, last event in the word wins
    always_comb begin
        in_frame_c = in_frame_o;
        nerr_c     = '0;
        for (int ln = 0; ln < `PCS_LANES; ln++) begin
            if (start_i[ln]) begin
                in_frame_c = 1'b1;
            end
            if (term_i[ln]) begin
                in_frame_c = 1'b0;
            end
            nerr_c = nerr_c + NERR_W'(err_i[ln]);
        end
    end

    // One spare bit to catch the wrap
    assign errd_sum = {1'b0, errd_blks_o} + {{(`ERRCNT_W+1-NERR_W){1'b0}}, nerr_c};

    //////////////////////////////////////////////////////////////////////
    // Status registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            valid_o    <= 1'b0;
            in_frame_o <= 1'b0;
        end else if (advance_i) begin
            valid_o <= valid_i;
            if (valid_i) begin
                in_frame_o <= in_frame_c;
            end
        end
    end

    // Clear acts even during a stall and beats any increment
    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            errd_blks_o <= '0;
        end else if (clear_errblk_i) begin
            errd_blks_o <= '0;
        end else if (advance_i && valid_i) begin
            if (errd_sum[`ERRCNT_W]) begin
                errd_blks_o <= '1;
            end else begin
                errd_blks_o <= errd_sum[`ERRCNT_W-1:0];
            end
        end
    end

    // Output word
    always_ff @(posedge clk_156) begin
        if (advance_i) begin
            rxc_o <= rxc_i;
            rxd_o <= rxd_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/pcs_rx_top.sv ====
//////////////////////////////////////////////////////////////////////
// 4-lane 10G PCS receive path
// Descrambler, block decoder and frame monitor in a three-stage
// pipeline, all stages frozen together by one advance enable
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pcs_rx_defines.svh"

module pcs_rx_top (
    input  wire                        clk_156,
    input  wire                        async_reset_n,
    input  wire                        in_valid_i,
    output logic                       in_ready_o,
    input  pcs_rx_pkg::lane_hdr_t      lane_hdr_i,
    input  pcs_rx_pkg::lane_payload_t  lane_payload_i,
    input  wire                        bypass_descram_i,
    input  wire                        clear_errblk_i,
    output logic                       out_valid_o,
    input  wire                        out_ready_i,
    output pcs_rx_pkg::lane_rxc_t      xgmii_rxc_o,
    output pcs_rx_pkg::lane_rxd_t      xgmii_rxd_o,
    output logic                       in_frame_o,
    output logic [`ERRCNT_W-1:0]       errd_blks_o
);

    logic                      advance;
    logic                      descr_valid;
    pcs_rx_pkg::lane_hdr_t     descr_hdr;
    pcs_rx_pkg::lane_payload_t descr_payload;
    logic                      dec_valid;
    pcs_rx_pkg::lane_rxc_t     dec_rxc;
    pcs_rx_pkg::lane_rxd_t     dec_rxd;
    logic [`PCS_LANES-1:0]     dec_start;
    logic [`PCS_LANES-1:0]     dec_term;
    logic [`PCS_LANES-1:0]     dec_err;

    // Whole pipeline moves when the output slot is free or being taken
    assign advance    = !out_valid_o || out_ready_i;
    assign in_ready_o = advance;

    rx_descrambler u_descr (
        .clk_156       (clk_156),
        .async_reset_n (async_reset_n),
        .advance_i     (advance),
        .valid_i       (in_valid_i),
        .hdr_i         (lane_hdr_i),
        .payload_i     (lane_payload_i),
        .bypass_i      (bypass_descram_i),
        .valid_o       (descr_valid),
        .hdr_o         (descr_hdr),
        .payload_o     (descr_payload)
    );

    block_decoder u_dec (
        .clk_156       (clk_156),
        .async_reset_n (async_reset_n),
        .advance_i     (advance),
        .valid_i       (descr_valid),
        .hdr_i         (descr_hdr),
        .payload_i     (descr_payload),
        .valid_o       (dec_valid),
        .rxc_o         (dec_rxc),
        .rxd_o         (dec_rxd),
        .start_o       (dec_start),
        .term_o        (dec_term),
        .err_o         (dec_err)
    );

    frame_monitor u_mon (
        .clk_156        (clk_156),
        .async_reset_n  (async_reset_n),
        .advance_i      (advance),
        .valid_i        (dec_valid),
        .rxc_i          (dec_rxc),
        .rxd_i          (dec_rxd),
        .start_i        (dec_start),
        .term_i         (dec_term),
        .err_i          (dec_err),
        .clear_errblk_i (clear_errblk_i),
        .valid_o        (out_valid_o),
        .rxc_o          (xgmii_rxc_o),
        .rxd_o          (xgmii_rxd_o),
        .in_frame_o     (in_frame_o),
        .errd_blks_o    (errd_blks_o)
    );

endmodule

`default_nettype wire

// ==== dv/pcs_rx_asserts.sv ====
//////////////////////////////////////////////////////////////////////
// PCS receive assertions
// Reset state, output hold stability and errored-block counter rules,
// bound into the receive top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pcs_rx_defines.svh"

module pcs_rx_asserts (
    input wire                       clk_156,
    input wire                       async_reset_n,
    input wire                       out_valid_o,
    input wire                       out_ready_i,
    input pcs_rx_pkg::lane_rxc_t     xgmii_rxc_o,
    input pcs_rx_pkg::lane_rxd_t     xgmii_rxd_o,
    input wire                       in_frame_o,
    input wire                       clear_errblk_i,
    input wire [`ERRCNT_W-1:0]       errd_blks_o
);

    int fail_cnt = 0;

    // Output stage empty while reset is held
    reset_empty: assert property (@(posedge clk_156) !async_reset_n |-> !out_valid_o)
        else begin
            $error("out_valid_o high during reset");
            fail_cnt++;
        end

    // Held word stays put until the sink takes it
    hold_stable: assert property (@(posedge clk_156) disable iff (!async_reset_n)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(xgmii_rxc_o)
            && $stable(xgmii_rxd_o) && $stable(in_frame_o))
        else begin
            $error("output word changed while held");
            fail_cnt++;
        end

    // Count only moves down through a clear
    errcnt_monotone: assert property (@(posedge clk_156) disable iff (!async_reset_n)
        !clear_errblk_i |=> errd_blks_o >= $past(errd_blks_o))
        else begin
            $error("errd_blks_o decreased without a clear");
            fail_cnt++;
        end

endmodule

bind pcs_rx_top pcs_rx_asserts u_asserts (.*);

`default_nettype wire

// ==== dv/pcs_rx_tb.sv ====
//////////////////////////////////////////////////////////////////////
// PCS receive testbench
// Scrambles random block streams, predicts the XGMII output with a
// reference model and compares every word that leaves the DUT
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pcs_rx_defines.svh"

module pcs_rx_tb;

    localparam int WAIT_LIMIT = 200;
    localparam int ERR_MAX    = (1 << `ERRCNT_W) - 1;

    logic                      clk_156 = 1'b0;
    logic                      async_reset_n;
    logic                      in_valid_i;
    logic                      in_ready_o;
    pcs_rx_pkg::lane_hdr_t     lane_hdr_i;
    pcs_rx_pkg::lane_payload_t lane_payload_i;
    logic                      bypass_descram_i;
    logic                      clear_errblk_i;
    logic                      out_valid_o;
    logic                      out_ready_i = 1'b1;
    pcs_rx_pkg::lane_rxc_t     xgmii_rxc_o;
    pcs_rx_pkg::lane_rxd_t     xgmii_rxd_o;
    logic                      in_frame_o;
    logic [`ERRCNT_W-1:0]      errd_blks_o;

    // Line side scrambler and reference model state
    logic [`SCR_TAP_B:0]       scr_hist = '0;
    logic [`SCR_TAP_B:0]       ref_hist = '0;
    logic                      ref_frame = 1'b0;
    int                        ref_errs = 0;
    pcs_rx_pkg::lane_rxc_t     exp_rxc_q[$];
    pcs_rx_pkg::lane_rxd_t     exp_rxd_q[$];
    logic                      exp_frame_q[$];
    int                        exp_errs_q[$];

    logic                      rand_ready = 1'b0;
    int                        errs = 0;
    int                        tests = 0;
    int                        test_start_errs = 0;

    always #2 clk_156 = ~clk_156;

    pcs_rx_top uut (.*);

    task automatic check_val(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got %0h expected %0h", name, got, exp);
            errs++;
        end
    endtask

    // Transmit model, history takes the bits as they go on the line
    function automatic pcs_rx_pkg::lane_payload_t scramble(
            input pcs_rx_pkg::lane_payload_t plain, input logic bypass);
        pcs_rx_pkg::lane_payload_t tx;
        logic                      sbit;
        for (int ln = 0; ln < `PCS_LANES; ln++) begin
            for (int b = 0; b < `PCS_PAYLOAD_W; b++) begin
                sbit = plain[ln][b];
                if (!bypass) sbit = sbit ^ scr_hist[`SCR_TAP_A] ^ scr_hist[`SCR_TAP_B];
                tx[ln][b] = sbit;
                scr_hist  = {scr_hist[`SCR_TAP_B-1:0], sbit};
            end
        end
        return tx;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model, descramble then decode then frame tracking
    //////////////////////////////////////////////////////////////////////
    function automatic void predict_word(input pcs_rx_pkg::lane_hdr_t hdr,
            input pcs_rx_pkg::lane_payload_t rx, input logic bypass);
        pcs_rx_pkg::lane_rxc_t rxc;
        pcs_rx_pkg::lane_rxd_t rxd;
        logic [63:0]           blk;
        for (int ln = 0; ln < `PCS_LANES; ln++) begin
            blk = rx[ln];
            for (int b = 0; b < `PCS_PAYLOAD_W; b++) begin
                if (!bypass) blk[b] = rx[ln][b] ^ ref_hist[`SCR_TAP_A] ^ ref_hist[`SCR_TAP_B];
                ref_hist = {ref_hist[`SCR_TAP_B-1:0], rx[ln][b]};
            end
            rxc[ln] = 8'hFF;
            rxd[ln] = {8{`XG_ERROR}};
            if (hdr[ln] == `HDR_DATA) begin
                rxc[ln] = 8'h00;
                rxd[ln] = blk;
            end else if (hdr[ln] == `HDR_CTRL && blk[7:0] == `BT_IDLE) begin
                rxd[ln] = {8{`XG_IDLE}};
            end else if (hdr[ln] == `HDR_CTRL && blk[7:0] == `BT_START) begin
                rxc[ln]   = 8'h01;
                rxd[ln]   = {blk[63:8], `XG_START};
                ref_frame = 1'b1;
            end else if (hdr[ln] == `HDR_CTRL && blk[7:0] == `BT_TERM0) begin
                rxd[ln]   = {{7{`XG_IDLE}}, `XG_TERM};
                ref_frame = 1'b0;
            end else if (ref_errs < ERR_MAX) begin
                ref_errs++;
            end
        end
        exp_rxc_q.push_back(rxc);
        exp_rxd_q.push_back(rxd);
        exp_frame_q.push_back(ref_frame);
        exp_errs_q.push_back(ref_errs);
    endfunction

    // Input transfers feed the model, a clear zeroes its count
    always @(posedge clk_156) begin
        if (async_reset_n && in_valid_i && in_ready_o) begin
            predict_word(lane_hdr_i, lane_payload_i, bypass_descram_i);
        end
        if (clear_errblk_i) begin
            ref_errs = 0;
        end
    end

    // Compare on every output transfer
    always @(posedge clk_156) begin
        if (async_reset_n && out_valid_o && !out_ready_i) begin
            check_val("in_ready_o", 256'(in_ready_o), 256'(0));
        end
        if (async_reset_n && out_valid_o && out_ready_i) begin
            if (exp_rxc_q.size() == 0) begin
                errs++;
                $display("output word appeared when none was expected");
            end else begin
                check_val("xgmii_rxc_o", 256'(xgmii_rxc_o), 256'(exp_rxc_q.pop_front()));
                check_val("xgmii_rxd_o", 256'(xgmii_rxd_o), 256'(exp_rxd_q.pop_front()));
                check_val("in_frame_o", 256'(in_frame_o), 256'(exp_frame_q.pop_front()));
                check_val("errd_blks_o", 256'(errd_blks_o), 256'(exp_errs_q.pop_front()));
            end
        end
    end

    // Sink, random back-pressure when enabled
    always @(negedge clk_156) begin
        out_ready_i <= rand_ready ? ($urandom % 2 == 0) : 1'b1;
    end

    task automatic timeout_abort(input string what);
        $display("timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
        $display("RESULT: FAIL");
        $finish;
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic send_word(input pcs_rx_pkg::lane_hdr_t hdr,
                             input pcs_rx_pkg::lane_payload_t plain);
        int cnt;
        cnt            = 0;
        lane_hdr_i     = hdr;
        lane_payload_i = scramble(plain, bypass_descram_i);
        in_valid_i     = 1'b1;
        @(posedge clk_156);
        while (!in_ready_o && cnt < WAIT_LIMIT) begin
            cnt++;
            @(posedge clk_156);
        end
        if (!in_ready_o) timeout_abort("in_ready_o");
        @(negedge clk_156);
        in_valid_i = 1'b0;
    endtask

    // Lane kinds 0 data, 1 idle, 2 start, 3 terminate, 4 bad header, 5 bad type
    task automatic send_kinds(input int k0, input int k1, input int k2, input int k3);
        pcs_rx_pkg::lane_hdr_t     hdr;
        pcs_rx_pkg::lane_payload_t pay;
        int                        kind;
        for (int ln = 0; ln < `PCS_LANES; ln++) begin
            kind    = (ln == 0) ? k0 : (ln == 1) ? k1 : (ln == 2) ? k2 : k3;
            pay[ln] = {$urandom, $urandom};
            hdr[ln] = (kind == 0) ? `HDR_DATA : `HDR_CTRL;
            case (kind)
                1: pay[ln][7:0] = `BT_IDLE;
                2: pay[ln][7:0] = `BT_START;
                3: pay[ln][7:0] = `BT_TERM0;
                4: hdr[ln] = ($urandom % 2 == 0) ? 2'b00 : 2'b11;
                5: pay[ln][7:0] = 8'h4B;
                default: ;
            endcase
        end
        send_word(hdr, pay);
    endtask

    function automatic int pick(input int lo, input int hi);
        return lo + int'($urandom % 32'(hi - lo + 1));
    endfunction

    task automatic send_random(input int n, input int lo, input int hi);
        for (int i = 0; i < n; i++) begin
            send_kinds(pick(lo, hi), pick(lo, hi), pick(lo, hi), pick(lo, hi));
            if ($urandom % 4 == 0) @(negedge clk_156);
        end
    endtask

    task automatic drain();
        int cnt;
        cnt = 0;
        while (exp_rxc_q.size() != 0 && cnt < WAIT_LIMIT) begin
            cnt++;
            @(negedge clk_156);
        end
        if (exp_rxc_q.size() != 0) timeout_abort("the output queue to drain");
    endtask

    task automatic end_test(input string name);
        drain();
        tests++;
        $display("test %s finished with %0d errors", name, errs - test_start_errs);
        test_start_errs = errs;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(70943));
        async_reset_n    = 1'b0;
        in_valid_i       = 1'b0;
        lane_hdr_i       = '0;
        lane_payload_i   = '0;
        bypass_descram_i = 1'b1;
        clear_errblk_i   = 1'b0;
        repeat (2) @(posedge clk_156);
        @(negedge clk_156);
        async_reset_n = 1'b1;
        check_val("out_valid_o", 256'(out_valid_o), 256'(0));
        check_val("in_frame_o", 256'(in_frame_o), 256'(0));
        check_val("errd_blks_o", 256'(errd_blks_o), 256'(0));
        end_test("reset");

        send_random(20, 0, 0);
        end_test("bypass_data");

        bypass_descram_i = 1'b0;
        send_random(40, 0, 0);
        end_test("descramble");

        send_random(30, 0, 3);
        end_test("control_blocks");

        // Enough errored lanes to reach saturation
        send_random(70, 4, 5);
        drain();
        check_val("errd_blks_o", 256'(errd_blks_o), 256'(ERR_MAX));
        clear_errblk_i = 1'b1;
        @(negedge clk_156);
        clear_errblk_i = 1'b0;
        check_val("errd_blks_o", 256'(errd_blks_o), 256'(0));
        end_test("errored_blocks");

        rand_ready = 1'b1;
        send_random(60, 0, 5);
        rand_ready = 1'b0;
        end_test("backpressure");

        // Start and terminate spread over lanes and words
        send_kinds(0, 0, 2, 0);
        send_kinds(0, 0, 0, 0);
        send_kinds(0, 3, 1, 1);
        send_kinds(2, 0, 0, 3);
        send_kinds(3, 1, 1, 2);
        send_kinds(0, 0, 0, 0);
        send_kinds(1, 3, 0, 0);
        drain();
        check_val("in_frame_o", 256'(in_frame_o), 256'(ref_frame));
        end_test("frame_tracking");

        $display("tests run %0d, errors %0d, assertion failures %0d",
                 tests, errs, uut.u_asserts.fail_cnt);
        if (errs == 0 && uut.u_asserts.fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+design
design/pcs_rx_pkg.sv
design/rx_descrambler.sv
design/block_decoder.sv
design/frame_monitor.sv
design/pcs_rx_top.sv
dv/pcs_rx_asserts.sv
dv/pcs_rx_tb.sv

// ==== Makefile ====
# Verilator build and run of the PCS receive testbench

VERILATOR ?= verilator
TOP       ?= pcs_rx_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
